// File: Makefile
TOP = tb_tm_scroll

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// File: rtl/tm_column_ctrl.sv
/*
 * Column scheduler for the tile layer.
 * After each sync it walks columns 0 to ncol-1, two tiles per column,
 * reading the column scroll and the tile-map words, and hands one
 * draw command per tile to the draw engine. Steps only when cen is high.
 */
module tm_column_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cen,
    input  logic                          hs,
    input  logic [8:0]                    vrender,
    input  logic                          page,
    input  logic [tm_pkg::COL_W-1:0]      ncol,
    input  logic [2**tm_pkg::COL_W-1:0]   col_xmsb,
    output logic [10:0]                   tm_addr,
    input  logic [15:0]                   tm_data,
    output logic [tm_pkg::COL_W:0]        col_addr,
    input  logic [7:0]                    col_data,
    output tm_pkg::tile_cmd_t             cmd,
    output logic                          draw,
    input  logic                          busy,
    output logic                          line_done
);

    // Step within the tile: y scroll, x scroll, code word, attribute
    logic [1:0]               st;
    // Tile counter, column above half
    logic [tm_pkg::COL_W:0]   tile_cnt;
    logic [tm_pkg::COL_W:0]   last_tile;
    logic                     done;
    logic [tm_pkg::COL_W-1:0] col;
    logic                     half;

    // Values gathered over the four steps
    logic [7:0]  yscr;
    logic [8:0]  xscr;
    logic        hflip;
    logic        vflip;
    logic [12:0] code;
    logic [7:0]  row_sum;
    logic        step;

    assign col  = tile_cnt[tm_pkg::COL_W:1];
    assign half = tile_cnt[0];

    // Right half of the last enabled column
    assign last_tile = {ncol - 1'b1, 1'b1};

    // Scrolled line within the tile map, 8-bit wrap
    assign row_sum = vrender[7:0] + yscr;

    // Step 0 reads y scroll, step 1 the x scroll low byte
    assign col_addr = {col, st[0]};

    // Step 2 reads the code word, step 3 the attribute word
    assign tm_addr = {page, st[0], col, row_sum[7:4], half};

    assign step = !hs && !done && cen;

    // Finished once the last command is taken and the engine is idle
    assign line_done = done & ~busy & ~draw;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= 2'd0;
            tile_cnt <= '0;
            done     <= 1'b1;
            draw     <= 1'b0;
        end else begin
            draw <= 1'b0;
            if (hs) begin
                // Held idle during sync, restart from column 0
                st       <= 2'd0;
                tile_cnt <= '0;
                done     <= ncol == '0;
            end else if (step) begin
                if (st != 2'd3) begin
                    st <= st + 2'd1;
                end else if (!busy) begin
                    // Issue and move to the next tile
                    draw     <= 1'b1;
                    st       <= 2'd0;
                    tile_cnt <= tile_cnt + 1'b1;
                    done     <= tile_cnt == last_tile;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            case (st)
                2'd0: yscr <= col_data;
                2'd1: xscr <= {col_xmsb[col], col_data};
                2'd2: begin
                    hflip <= tm_data[15];
                    vflip <= tm_data[14];
                    code  <= tm_data[12:0];
                end
                default: begin
                    if (!busy) begin
                        cmd.code  <= code;
                        cmd.pal   <= tm_data[15:11];
                        cmd.hflip <= hflip;
                        cmd.vflip <= vflip;
                        // Right tile sits 16 pixels further on
                        cmd.xpos  <= xscr + {4'd0, half, 4'd0};
                        cmd.ysub  <= row_sum[3:0] ^ {4{vflip}};
                    end
                end
            endcase
        end
    end

endmodule

// File: rtl/tm_line_buf.sv
/*
 * Ping-pong line buffer.
 * One half is written by the draw engine while the other is read out
 * at hdump. Halves swap on the rising edge of hs, and during hs the
 * write half is cleared at hdump, one address per cycle.
 */
module tm_line_buf #(
    parameter int LINE_AW = 9,
    parameter int PXL_W   = 9
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               hs,
    input  logic [LINE_AW-1:0] hdump,
    input  tm_pkg::buf_wr_t    wr,
    output logic [PXL_W-1:0]   pxl
);

    logic [PXL_W-1:0]   mem [0:2**(LINE_AW+1)-1];
    logic               hs_l;
    logic               half;
    // Write half, already swapped in the first hs cycle
    logic               cur_half;
    logic               mux_we;
    logic [LINE_AW-1:0] mux_addr;
    logic [PXL_W-1:0]   mux_din;

    assign cur_half = half ^ (hs & ~hs_l);

    // Sync clearing takes over the write port
    assign mux_we   = hs ? 1'b1 : wr.we;
    assign mux_addr = hs ? hdump : wr.addr;
    assign mux_din  = hs ? '0 : wr.data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hs_l <= 1'b0;
            half <= 1'b0;
            pxl  <= '0;
        end else begin
            hs_l <= hs;
            half <= cur_half;
            // Previous line, one clock behind hdump
            pxl  <= mem[{~cur_half, hdump}];
        end
    end

    always_ff @(posedge clk) begin
        if (mux_we) begin
            mem[{cur_half, mux_addr}] <= mux_din;
        end
    end

endmodule

// File: rtl/tm_pkg.sv
/*
 * Shared sizes and packed types for the tile-layer renderer.
 * The column control, draw engine, line buffer and top level all
 * refer to these by scoped name, so a size changes in one place.
 */
package tm_pkg;

    // Line buffer address width per half, 512 positions
    localparam int LINE_AW = 9;

    // Stored pixel: 5 palette bits above 4 colour bits
    localparam int PXL_W = 9;

    // Column index, up to 16 columns
    localparam int COL_W = 4;

    // ROM word address: code, tile row, left/right word
    localparam int ROM_AW = 18;

    // Draw command from the column control to the draw engine
    typedef struct packed {
        logic [12:0] code;
        logic [4:0]  pal;
        logic        hflip;
        logic        vflip;
        // Screen position of the leftmost pixel, wraps at 512
        logic [8:0]  xpos;
        // Tile row, already inverted for vflip
        logic [3:0]  ysub;
    } tile_cmd_t;

    // One line buffer write, sent every cycle
    typedef struct packed {
        // High only for opaque pixels
        logic       we;
        logic [8:0] addr;
        logic [8:0] data;
    } buf_wr_t;

endpackage

// File: rtl/tm_scroll_top.sv
/*
 * Tile layer with per-column scroll.
 * Joins the column scheduler, the draw engine and the line buffer.
 * Tile-map, column-scroll and graphics ROM sit outside this block.
 */
module tm_scroll_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cen,
    input  logic                          hs,
    input  logic [8:0]                    vrender,
    input  logic [tm_pkg::LINE_AW-1:0]    hdump,
    input  logic                          page,
    input  logic [tm_pkg::COL_W-1:0]      ncol,
    input  logic [2**tm_pkg::COL_W-1:0]   col_xmsb,
    output logic [10:0]                   tm_addr,
    input  logic [15:0]                   tm_data,
    output logic [tm_pkg::COL_W:0]        col_addr,
    input  logic [7:0]                    col_data,
    output logic [tm_pkg::ROM_AW-1:0]     rom_addr,
    output logic                          rom_cs,
    input  logic                          rom_ok,
    input  logic [31:0]                   rom_data,
    output logic [tm_pkg::PXL_W-1:0]      pxl,
    output logic                          line_done
);

    tm_pkg::tile_cmd_t cmd;
    tm_pkg::buf_wr_t   wr;
    logic              draw;
    logic              busy;

    tm_column_ctrl u_column_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .hs        (hs),
        .vrender   (vrender),
        .page      (page),
        .ncol      (ncol),
        .col_xmsb  (col_xmsb),
        .tm_addr   (tm_addr),
        .tm_data   (tm_data),
        .col_addr  (col_addr),
        .col_data  (col_data),
        .cmd       (cmd),
        .draw      (draw),
        .busy      (busy),
        .line_done (line_done)
    );

    tm_tile_draw u_tile_draw (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .draw     (draw),
        .busy     (busy),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .wr       (wr)
    );

    tm_line_buf #(
        .LINE_AW (tm_pkg::LINE_AW),
        .PXL_W   (tm_pkg::PXL_W)
    ) u_line_buf (
        .clk   (clk),
        .rst   (rst),
        .hs    (hs),
        .hdump (hdump),
        .wr    (wr),
        .pxl   (pxl)
    );

endmodule

// File: rtl/tm_tile_draw.sv
/*
 * Tile draw engine.
 * Takes one draw command, fetches the left and right graphics words
 * from ROM and shifts out 16 pixels, one per cycle, as line buffer
 * writes. Colour 0 is transparent and produces no write.
 */
module tm_tile_draw (
    input  logic                        clk,
    input  logic                        rst,
    input  tm_pkg::tile_cmd_t           cmd,
    input  logic                        draw,
    output logic                        busy,
    output logic [tm_pkg::ROM_AW-1:0]   rom_addr,
    output logic                        rom_cs,
    input  logic                        rom_ok,
    input  logic [31:0]                 rom_data,
    output tm_pkg::buf_wr_t             wr
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        SHIFT
    } state_t;

    state_t            state;
    tm_pkg::tile_cmd_t cur;
    // Source pixel index, bit 3 picks the word
    logic [3:0]        cnt;
    logic [31:0]       pix;
    logic [3:0]        off;

    assign busy = state != IDLE;

    // Held steady for the whole fetch
    assign rom_addr = {cur.code, cur.ysub, cnt[3]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            cnt    <= 4'd0;
            rom_cs <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (draw) begin
                        state  <= FETCH;
                        rom_cs <= 1'b1;
                        cnt    <= 4'd0;
                    end
                end
                FETCH: begin
                    // Wait for the ROM, drop select right after
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        state  <= SHIFT;
                    end
                end
                default: begin
                    cnt <= cnt + 4'd1;
                    if (cnt[2:0] == 3'd7) begin
                        if (!cnt[3]) begin
                            // Left word done, fetch the right one
                            state  <= FETCH;
                            rom_cs <= 1'b1;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && draw) begin
            cur <= cmd;
        end
        if (state == FETCH && rom_ok) begin
            pix <= rom_data;
        end else if (state == SHIFT) begin
            // Nibble 0 is the leftmost pixel
            pix <= pix >> 4;
        end
    end

    // hflip mirrors the 16 positions
    assign off = cnt ^ {4{cur.hflip}};

    always_comb begin
        wr.we   = state == SHIFT && pix[3:0] != 4'd0;
        wr.addr = cur.xpos + {5'd0, off};
        wr.data = {cur.pal, pix[3:0]};
    end

endmodule

// File: tb.f
rtl/tm_pkg.sv
rtl/tm_column_ctrl.sv
rtl/tm_tile_draw.sv
rtl/tm_line_buf.sv
rtl/tm_scroll_top.sv
testbench/tb_tm_mem.sv
testbench/tb_tm_scroll.sv

// File: testbench/tb_tm_mem.sv
/*
 * Behavioural memories for the tile-layer testbench.
 * Tile-map and column-scroll RAMs answer combinationally. The graphics
 * ROM answers a held select after a random 0 to 5 cycle delay.
 * Also drives the random clock enable and a free-running random word.
 */
module tb_tm_mem (
    input  logic        clk,
    input  logic        rst,
    // Columns at 32 pixel steps, no y scroll, flips forced off
    input  logic        plain,
    input  logic [7:0]  scr_key,
    input  logic [10:0] tm_addr,
    output logic [15:0] tm_data,
    input  logic [4:0]  col_addr,
    output logic [7:0]  col_data,
    input  logic [17:0] rom_addr,
    input  logic        rom_cs,
    output logic        rom_ok,
    output logic [31:0] rom_data,
    output logic        cen,
    output logic [31:0] rnd
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h4f38_32ba;

    logic [15:0] tile_mem [0:2047];
    logic [7:0]  col_mem [0:31];
    logic [31:0] rom [0:2**18-1];
    logic [31:0] rng;
    // Cycles left before the next ROM answer
    logic [2:0]  wait_cnt;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // One random stream fills all three memories
    initial begin
        logic [31:0] s;
        s = SEED;
        for (int a = 0; a < 2048; a++) begin
            s = xorshift(s);
            tile_mem[a] = s[15:0];
        end
        for (int a = 0; a < 32; a++) begin
            s = xorshift(s);
            col_mem[a] = s[7:0];
        end
        for (int a = 0; a < 2**18; a++) begin
            s = xorshift(s);
            rom[a] = s;
        end
    end

    // Code words (select bit 9 low) lose their flip bits in plain mode
    assign tm_data  = (plain && !tm_addr[9]) ? {2'b00, tile_mem[tm_addr][13:0]}
                                             : tile_mem[tm_addr];
    // Plain mode puts column c at x low byte 32c, y scroll zero
    assign col_data = !plain      ? col_mem[col_addr] ^ scr_key :
                      col_addr[0] ? {col_addr[3:1], 5'd0} : 8'd0;
    assign rnd      = rng;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rng      <= SEED;
            cen      <= 1'b0;
            rom_ok   <= 1'b0;
            rom_data <= '0;
            wait_cnt <= 3'd2;
        end else begin
            rng <= xorshift(rng);
            // High about three cycles in four
            cen <= rng[9:8] != 2'b00;
            if (rom_ok) begin
                rom_ok <= 1'b0;
            end else if (rom_cs) begin
                if (wait_cnt == 3'd0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom[rom_addr];
                    // Delay for the next request
                    wait_cnt <= 3'(rng[20:16] % 5'd6);
                end else begin
                    wait_cnt <= wait_cnt - 3'd1;
                end
            end
        end
    end

endmodule

// File: testbench/tb_tm_scroll.sv
/*
 * Testbench for the tile layer with column scroll.
 * Each line is drawn with hs low, then read back during the next sync
 * sweep and compared with a model of the column, tile and pixel rules.
 * Covers reset, layer off, plain tiles, random scroll, flips, palettes,
 * ROM delays and clock-enable gaps.
 */
module tb_tm_scroll;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LINES    = 40;
    localparam int DONE_TIMEOUT = 5000;

    logic        clk;
    logic        rst;
    logic        cen;
    logic        hs;
    logic [8:0]  vrender;
    logic [8:0]  hdump;
    logic        page;
    logic [3:0]  ncol;
    logic [15:0] col_xmsb;
    logic [10:0] tm_addr;
    logic [15:0] tm_data;
    logic [4:0]  col_addr;
    logic [7:0]  col_data;
    logic [17:0] rom_addr;
    logic        rom_cs;
    logic        rom_ok;
    logic [31:0] rom_data;
    logic [8:0]  pxl;
    logic        line_done;
    logic        plain;
    logic [7:0]  scr_key;
    logic [31:0] rnd;

    // Expected read-out of the line just drawn
    logic [8:0]  exp_line [0:511];
    logic        checking;
    // hdump and check enable seen at the last rising edge
    logic [8:0]  rd_h;
    logic        rd_v;

    tm_scroll_top u_tm_scroll_top (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .hs        (hs),
        .vrender   (vrender),
        .hdump     (hdump),
        .page      (page),
        .ncol      (ncol),
        .col_xmsb  (col_xmsb),
        .tm_addr   (tm_addr),
        .tm_data   (tm_data),
        .col_addr  (col_addr),
        .col_data  (col_data),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .rom_ok    (rom_ok),
        .rom_data  (rom_data),
        .pxl       (pxl),
        .line_done (line_done)
    );

    tb_tm_mem u_mem (
        .clk      (clk),
        .rst      (rst),
        .plain    (plain),
        .scr_key  (scr_key),
        .tm_addr  (tm_addr),
        .tm_data  (tm_data),
        .col_addr (col_addr),
        .col_data (col_data),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .cen      (cen),
        .rnd      (rnd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("ERROR: time %0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
        $display("tests failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic report_failure(input string what);
        $display("Failure at time %0t: %s", $time, what);
        $display("tests failed");
        $fatal(1, "stopping on first error");
    endtask

    // Model of one line, built from the scroll, tile-map and ROM contents
    task automatic build_expected();
        logic [3:0]  col;
        logic        half;
        logic [7:0]  yscr;
        logic [8:0]  xscr;
        logic [7:0]  row_sum;
        logic [15:0] code_w;
        logic [15:0] attr_w;
        logic [3:0]  ysub;
        logic [8:0]  xpos;
        logic [8:0]  addr;
        logic [3:0]  src;
        logic [31:0] word;
        logic [3:0]  nib;
        for (int i = 0; i < 512; i++) begin
            exp_line[i] = '0;
        end
        // Tiles in issue order, so a later tile overwrites
        for (int t = 0; t < 2 * int'(ncol); t++) begin
            col  = 4'(t >> 1);
            half = t[0];
            if (plain) begin
                // Each column at its own 32 pixel slot
                yscr = 8'd0;
                xscr = 9'(32 * int'(col));
            end else begin
                yscr = u_mem.col_mem[{col, 1'b0}] ^ scr_key;
                xscr = {col_xmsb[col], u_mem.col_mem[{col, 1'b1}] ^ scr_key};
            end
            row_sum = vrender[7:0] + yscr;
            code_w  = u_mem.tile_mem[{page, 1'b0, col, row_sum[7:4], half}];
            attr_w  = u_mem.tile_mem[{page, 1'b1, col, row_sum[7:4], half}];
            if (plain) begin
                code_w[15:14] = 2'b00;
            end
            // vflip inverts the row, hflip mirrors the 16 pixels
            ysub = code_w[14] ? ~row_sum[3:0] : row_sum[3:0];
            xpos = xscr + (half ? 9'd16 : 9'd0);
            for (int p = 0; p < 16; p++) begin
                src  = code_w[15] ? 4'(15 - p) : 4'(p);
                word = u_mem.rom[{code_w[12:0], ysub, src[3]}];
                nib  = word[{src[2:0], 2'b00} +: 4];
                addr = xpos + 9'(p);
                if (nib != 4'd0) begin
                    exp_line[addr] = {attr_w[15:11], nib};
                end
            end
        end
    endtask

    // Line 0 and 5 off, 1 to 4 plain tiles, then all random
    task automatic apply_config(input int line);
        logic [31:0] r;
        r = rnd;
        if (line == 0 || line == 5) begin
            ncol     <= '0;
            plain    <= 1'b0;
            col_xmsb <= '0;
            scr_key  <= '0;
        end else if (line < 5) begin
            ncol     <= 4'd15;
            plain    <= 1'b1;
            // Columns 8 and up sit past x 255
            col_xmsb <= 16'hff00;
            scr_key  <= '0;
            vrender  <= r[8:0];
            page     <= r[9];
        end else begin
            ncol     <= r[3:0];
            plain    <= 1'b0;
            vrender  <= r[12:4];
            page     <= r[13];
            scr_key  <= r[21:14];
            col_xmsb <= r[31:16];
        end
    endtask

    // One sync period with hdump over the whole line
    task automatic sweep(input bit check, input int next_line);
        checking = check;
        @(posedge clk);
        hs    <= 1'b1;
        hdump <= '0;
        apply_config(next_line);
        for (int h = 1; h < 512; h++) begin
            @(posedge clk);
            hdump <= 9'(h);
        end
        @(posedge clk);
        hs <= 1'b0;
    endtask

    task automatic wait_line_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        // Layer off means done at once
        if (ncol == '0) begin
            assert (line_done) else report_mismatch("line_done", 32'd1, 32'(line_done));
        end
        while (!line_done) begin
            @(negedge clk);
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                report_failure("timeout waiting for line_done after sync");
            end
        end
    endtask

    always @(posedge clk) begin
        rd_h <= hdump;
        rd_v <= hs & checking;
    end

    // pxl holds the pixel for the hdump of the last edge
    always @(negedge clk) begin
        if (rd_v) begin
            assert (pxl == exp_line[rd_h])
                else report_mismatch("pxl", 32'(exp_line[rd_h]), 32'(pxl));
        end
    end

    initial begin
        checking = 1'b0;
        rst      <= 1'b1;
        hs       <= 1'b0;
        hdump    <= '0;
        vrender  <= '0;
        page     <= 1'b0;
        ncol     <= '0;
        col_xmsb <= '0;
        plain    <= 1'b0;
        scr_key  <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (rom_cs == 1'b0) else report_mismatch("rom_cs", 32'd0, 32'(rom_cs));
        assert (line_done == 1'b1) else report_mismatch("line_done", 32'd1, 32'(line_done));
        // Clearing sweep, unchecked
        sweep(1'b0, 0);
        for (int n = 0; n < NUM_LINES; n++) begin
            wait_line_done();
            build_expected();
            sweep(1'b1, n + 1);
        end
        $display("all tests passed");
        $finish;
    end

endmodule
